// ==== accel_pkg.sv ====
// shared definitions for the dual channel adxl355 reader
// frame constants, wishbone register map and the structs between blocks
package accel_pkg;

  localparam int SCLK_DIV    = 4;   // clk cycles per half-bit tick
  localparam int MAX_LEN     = 10;  // cmd byte plus 9 xyz bytes
  localparam int KEEP_BYTES  = 6;   // 16-bit relevant bytes per channel
  localparam int STORE_BYTES = 12;  // ch0 in the lower half, ch1 in the upper

  // wishbone word addresses
  localparam logic [3:0] REG_CTRL    = 4'd0;
  localparam logic [3:0] REG_STATUS  = 4'd1;
  localparam logic [3:0] REG_SAMPLE0 = 4'd2;  // three words follow

  // frame setup, latched when a frame starts
  typedef struct packed {
    logic [7:0] cmd;  // first byte on mosi
    logic [3:0] len;  // frame bytes incl. cmd
  } xfer_cfg_t;

  typedef struct packed {
    logic sclk;
    logic mosi;
    logic csn;
  } spi_pins_t;

  // control register layout
  typedef struct packed {
    logic [14:0] rsvd_hi;  // 31:17
    logic        direct;   // request direct pin access
    logic [3:0]  rsvd_lo;  // 15:12
    logic [3:0]  len;
    logic [7:0]  cmd;
  } ctrl_reg_t;

  typedef struct packed {
    logic       valid;  // one clk per data byte
    logic [7:0] ch0;
    logic [7:0] ch1;
  } rx_byte_t;

  typedef struct packed {
    logic       en;
    logic [3:0] addr;  // store byte address
    logic [7:0] data;
  } store_wr_t;

endpackage

// ==== accel_reader_top.sv ====
// dual channel adxl355 spi reader with wishbone access
// the sensor pins go to the reader or straight to the external pins
`timescale 1ns/10ps

module accel_reader_top import accel_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [3:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack,
  input  logic        sync,
  input  logic        ext_sclk,
  input  logic        ext_mosi,
  input  logic        ext_csn,
  output logic        adxl_sclk,
  output logic        adxl_mosi,
  output logic        adxl_csn,
  input  logic        adxl0_miso,
  input  logic        adxl1_miso
);

  logic       tick;
  logic       run;
  logic       drain;
  logic       drain_done;
  logic       busy;
  logic       direct_en;
  logic       frame_done;
  logic       frame_start;
  logic       shift_mosi;
  logic [7:0] half_cnt;
  xfer_cfg_t  cfg;
  spi_pins_t  fsm_pins;
  spi_pins_t  rdr_pins;
  spi_pins_t  ext_pins;
  spi_pins_t  adxl_pins;
  rx_byte_t   rx;
  store_wr_t  store_wr;
  ctrl_reg_t  ctrl;

  assign frame_start = tick && (half_cnt == 8'd0);  // select tick, no data yet

  sclk_timer u_timer (.clk, .rst, .run, .tick, .half_cnt);

  xfer_fsm u_fsm (
    .clk, .rst, .tick, .half_cnt, .sync, .ctrl, .drain_done,
    .run, .cfg, .pins(fsm_pins), .drain, .busy, .direct_en, .frame_done
  );

  spi_shift u_shift (
    .clk, .rst, .tick, .half_cnt, .cfg,
    .miso0(adxl0_miso), .miso1(adxl1_miso), .mosi(shift_mosi), .rx
  );

  sample_pack u_pack (
    .clk, .rst, .rx, .start(frame_start), .drain, .drain_done, .wr(store_wr)
  );

  wb_regs u_regs (
    .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .store_wr, .busy, .direct_en, .frame_done, .ctrl
  );

  // reader pins with the shifter's mosi, host pins as given
  assign rdr_pins  = '{sclk: fsm_pins.sclk, mosi: shift_mosi, csn: fsm_pins.csn};
  assign ext_pins  = '{sclk: ext_sclk, mosi: ext_mosi, csn: ext_csn};
  assign adxl_pins = direct_en ? ext_pins : rdr_pins;

  assign adxl_sclk = adxl_pins.sclk;
  assign adxl_mosi = adxl_pins.mosi;
  assign adxl_csn  = adxl_pins.csn;

endmodule

// ==== sample_pack.sv ====
// sample packer for the two sensor channels
// drops every 3rd data byte, ch0 goes straight to the store, ch1 drains after csn
`timescale 1ns/10ps

module sample_pack import accel_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  rx_byte_t  rx,
  input  logic      start,
  input  logic      drain,
  output logic      drain_done,
  output store_wr_t wr
);

  logic [7:0] ch1_buf [KEEP_BYTES];  // ch1 side buffer
  logic [1:0] phase;     // byte position inside a 20-bit axis
  logic [2:0] kept;      // kept bytes this frame
  logic [2:0] rd_idx;    // drain pointer
  logic       draining;
  logic       keep;
  logic       wr_en;
  logic [3:0] wr_addr;
  logic [7:0] wr_data;

  // third byte of an axis only holds the low nibble
  assign keep = rx.valid && (phase != 2'd2) && (kept < 3'(KEEP_BYTES));
  assign wr   = '{en: wr_en, addr: wr_addr, data: wr_data};

  always_ff @(posedge clk)
  begin
    if (keep)
      ch1_buf[kept] <= rx.ch1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      phase      <= '0;
      kept       <= '0;
      rd_idx     <= '0;
      draining   <= 1'b0;
      drain_done <= 1'b0;
      wr_en      <= 1'b0;
    end
    else
    begin
      // high with the last drain write on the bus
      drain_done <= draining && (rd_idx == 3'(KEEP_BYTES - 1));
      if (start)
      begin
        phase <= '0;
        kept  <= '0;
      end
      else if (rx.valid)
      begin
        phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
        if (keep)
          kept <= kept + 3'd1;
      end
      if (drain)
      begin
        draining <= 1'b1;
        rd_idx   <= '0;
      end
      else if (draining)
      begin
        rd_idx <= rd_idx + 3'd1;
        if (rd_idx == 3'(KEEP_BYTES - 1))
          draining <= 1'b0;  // always 6 clks
      end
      wr_en <= keep || (draining && (rd_idx < kept));  // short frames touch fewer bytes
    end
  end

  always_ff @(posedge clk)
  begin
    if (draining)
    begin
      wr_addr <= 4'(KEEP_BYTES) + {1'b0, rd_idx};  // upper half
      wr_data <= ch1_buf[rd_idx];
    end
    else
    begin
      wr_addr <= {1'b0, kept};
      wr_data <= rx.ch0;
    end
  end

endmodule

// ==== sclk_timer.sv ====
// half-bit tick generator for the spi clock
// counts half-bits within a frame and sits at zero between frames
`timescale 1ns/10ps

module sclk_timer import accel_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       run,
  output logic       tick,
  output logic [7:0] half_cnt
);

  logic [$clog2(SCLK_DIV)-1:0] div_cnt;  // clk divider

  // tick only while a frame runs
  assign tick = run && (int'(div_cnt) == SCLK_DIV - 1);

  always_ff @(posedge clk)
  begin
    if (rst || !run)
    begin
      div_cnt  <= '0;  // frames always start aligned
      half_cnt <= '0;
    end
    else
    begin
      div_cnt <= tick ? '0 : div_cnt + 1'b1;
      if (tick)
        half_cnt <= half_cnt + 8'd1;  // next half-bit
    end
  end

endmodule

// ==== spi_shift.sv ====
// spi shifters for the reader
// cmd byte out on mosi, both miso lines in, one strobe per data byte
`timescale 1ns/10ps

module spi_shift import accel_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       tick,
  input  logic [7:0] half_cnt,
  input  xfer_cfg_t  cfg,
  input  logic       miso0,
  input  logic       miso1,
  output logic       mosi,
  output rx_byte_t   rx
);

  logic [7:0] tx_sr;     // command shifter, msb first
  logic [7:0] rx0_sr;
  logic [7:0] rx1_sr;
  logic [6:0] bit_idx;   // bit within the frame on a rising edge
  logic       in_frame;
  logic       rise;
  logic       fall;
  logic       rx_valid;

  assign in_frame = (half_cnt != 8'd0) && (half_cnt <= {cfg.len, 4'h0});
  assign rise     = tick && in_frame && half_cnt[0];   // sclk goes high
  assign fall     = tick && in_frame && !half_cnt[0];  // sclk goes low
  assign bit_idx  = half_cnt[7:1];
  assign mosi     = tx_sr[7];
  assign rx       = '{valid: rx_valid, ch0: rx0_sr, ch1: rx1_sr};

  always_ff @(posedge clk)
  begin
    if (rst)
      tx_sr <= '0;
    else if (half_cnt == 8'd0)
      tx_sr <= cfg.cmd;  // msb ready before the first rising edge
    else if (fall)
      tx_sr <= {tx_sr[6:0], 1'b0};
  end

  // sensors are sampled on the rising edge
  always_ff @(posedge clk)
  begin
    if (rise)
    begin
      rx0_sr <= {rx0_sr[6:0], miso0};
      rx1_sr <= {rx1_sr[6:0], miso1};
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      rx_valid <= 1'b0;
    else  // last bit of a byte, the byte under the cmd is dummy
      rx_valid <= rise && (bit_idx[2:0] == 3'd7) && (bit_idx[6:3] != 4'd0);
  end

endmodule

// ==== tb.f ====
accel_pkg.sv
sclk_timer.sv
xfer_fsm.sv
spi_shift.sv
sample_pack.sv
wb_regs.sv
accel_reader_top.sv
tb_accel_reader.sv

// ==== tb_accel_reader.sv ====
// testbench for the dual channel adxl355 reader
// two sensor models on miso, a wishbone master, checks by assertions
`timescale 1ns/10ps

module tb_accel_reader import accel_pkg::*;
();

  logic        clk;
  logic        rst;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic [3:0]  wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        sync;
  logic        ext_sclk;
  logic        ext_mosi;
  logic        ext_csn;
  logic        adxl_sclk;
  logic        adxl_mosi;
  logic        adxl_csn;
  logic        adxl0_miso;
  logic        adxl1_miso;

  logic [31:0] rng = 32'h900e_7573;  // shared by both sensor models
  logic [7:0]  tx0 = '0;             // byte on the wire, ch0
  logic [7:0]  tx1 = '0;
  logic [7:0]  sent0 [16];           // bytes sent this frame, by position
  logic [7:0]  sent1 [16];
  logic [7:0]  exp_store [STORE_BYTES] = '{default: 8'h00};
  logic [7:0]  got_store [STORE_BYTES];
  logic [7:0]  mosi_cap;             // first 8 mosi bits of a frame
  logic [7:0]  fcnt = '0;            // expected frame count
  logic        csn_q = 1'b1;
  logic        sclk_q = 1'b0;
  int          byte_no = 0;
  int          bit_no = 0;
  int          rises = 0;            // rising sclk while csn low
  int          errors = 0;
  int          checks = 0;
  int          err_mark = 0;
  int          test_no = 1;
  int          cycles = 0;

  accel_reader_top dut (.*);

  always #10 clk = ~clk;

  // run limit from four full length frames plus slack
  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= 4 * (16 * MAX_LEN * SCLK_DIV + 40) + 500)
    begin
      $display("timeout after %0d cycles, the run did not finish", cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  ack_pulse: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
  else
  begin
    errors++;
    $display("wishbone ack stayed high for two cycles in a row");
  end

  sclk_idle: assert property (@(posedge clk) disable iff (rst) adxl_csn |-> !adxl_sclk)
  else
  begin
    errors++;
    $display("sclk was high while csn was high");
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic load_bytes();
    rng = xorshift(rng);
    tx0 = rng[7:0];
    tx1 = rng[15:8];
    if (byte_no < 16)
    begin
      sent0[byte_no] = tx0;
      sent1[byte_no] = tx1;
    end
  endtask

  // sensor models, first bit ready at csn fall, next bit after each sclk fall
  always @(posedge clk)
  begin
    #2;
    if (csn_q && !adxl_csn)
    begin
      byte_no  = 0;
      bit_no   = 0;
      rises    = 0;
      mosi_cap = '0;
      load_bytes();
    end
    else if (!adxl_csn && sclk_q && !adxl_sclk)
    begin
      bit_no++;
      if (bit_no == 8)
      begin
        bit_no = 0;
        byte_no++;
        load_bytes();
      end
    end
    if (!adxl_csn && !sclk_q && adxl_sclk)
    begin
      if (rises < 8)
        mosi_cap = {mosi_cap[6:0], adxl_mosi};  // cmd goes out msb first
      rises++;
    end
    adxl0_miso = tx0[7 - bit_no];
    adxl1_miso = tx1[7 - bit_no];
    csn_q  = adxl_csn;
    sclk_q = adxl_sclk;
  end

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1)
    else
    begin
      errors++;
      $display("%s", what);
    end
  endtask

  task automatic end_test(input string name);
    $display("test %0d %s: %0d errors", test_no, name, errors - err_mark);
    test_no++;
    err_mark = errors;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n)
    begin
      @(posedge clk);
      #2;
    end
  endtask

  // classic cycle, held until ack, called 2 ns after a rising edge
  task automatic wb_access(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    do
    begin
      @(posedge clk);
      #2;
    end
    while (!wb_ack);
    rdat   = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic read_reg(input logic [3:0] adr, output logic [31:0] data);
    wb_access(1'b0, adr, 32'h0, data);
  endtask

  task automatic write_reg(input logic [3:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    wb_access(1'b1, adr, data, unused);
  endtask

  task automatic pulse_sync();
    sync = 1'b1;
    wait_cycles(1);
    sync = 1'b0;
  endtask

  // one frame, optionally with a second sync while busy
  task automatic run_frame(input logic extra_sync);
    logic [31:0] st;
    pulse_sync();
    read_reg(REG_STATUS, st);
    check_true(st[0], "frame did not start, busy stayed low after sync");
    if (extra_sync)
      pulse_sync();
    while (st[0])
      read_reg(REG_STATUS, st);  // busy falls at the end of the drain
  endtask

  // expected store, every third data byte of an axis is dropped
  task automatic expect_frame(input int len);
    int n;
    n = 0;
    for (int j = 0; j < len - 1; j++)
      if (j % 3 != 2 && n < KEEP_BYTES)
      begin
        exp_store[n]              = sent0[j + 1];  // byte 0 sits under the cmd
        exp_store[KEEP_BYTES + n] = sent1[j + 1];
        n++;
      end
  endtask

  task automatic read_store();
    logic [31:0] word;
    for (int w = 0; w < STORE_BYTES / 4; w++)
    begin
      read_reg(REG_SAMPLE0 + 4'(w), word);
      for (int k = 0; k < 4; k++)
        got_store[4 * w + k] = word[8 * k +: 8];
    end
  endtask

  task automatic compare_store(input int lo, input int hi);
    for (int i = lo; i <= hi; i++)
      check_eq($sformatf("store[%0d]", i), got_store[i], exp_store[i]);
  endtask

  task automatic drive_ext(input logic s, input logic m, input logic c);
    ext_sclk = s;
    ext_mosi = m;
    ext_csn  = c;
    wait_cycles(1);
    check_eq("adxl_sclk", adxl_sclk, s);
    check_eq("adxl_mosi", adxl_mosi, m);
    check_eq("adxl_csn", adxl_csn, c);
  endtask

  initial
  begin
    logic [31:0] st;
    clk        = 1'b0;
    rst        = 1'b1;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    sync       = 1'b0;
    ext_sclk   = 1'b0;
    ext_mosi   = 1'b0;
    ext_csn    = 1'b1;
    adxl0_miso = 1'b0;
    adxl1_miso = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    rst = 1'b0;

    check_eq("adxl_csn", adxl_csn, 1'b1);
    check_eq("adxl_sclk", adxl_sclk, 1'b0);
    read_reg(REG_STATUS, st);
    check_eq("status", st, 32'h0);
    read_reg(REG_CTRL, st);
    check_eq("ctrl", st, 32'h0000_0a01);  // read id, full length
    write_reg(REG_CTRL, 32'h0000_0a21);
    read_reg(REG_CTRL, st);
    check_eq("ctrl", st, 32'h0000_0a21);
    read_reg(REG_STATUS, st);
    check_eq("status", st, 32'h0);
    end_test("reset state and control readback");

    run_frame(1'b0);
    expect_frame(10);
    fcnt++;
    check_eq("sclk rising edges", rises, 80);
    check_eq("adxl_mosi cmd", mosi_cap, 8'h21);
    end_test("command byte on mosi and sclk edge count");

    read_store();
    compare_store(0, KEEP_BYTES - 1);
    end_test("channel 0 bytes in the store");

    compare_store(KEEP_BYTES, STORE_BYTES - 1);
    read_reg(REG_STATUS, st);
    check_eq("status", st, {16'd0, fcnt, 8'h00});
    end_test("channel 1 bytes and frame count");

    write_reg(REG_CTRL, 32'h0000_0421);  // three data bytes
    run_frame(1'b1);
    expect_frame(4);
    fcnt++;
    wait_cycles(20);  // an extra frame would still be busy here
    read_reg(REG_STATUS, st);
    check_eq("status", st, {16'd0, fcnt, 8'h00});
    read_store();
    compare_store(0, STORE_BYTES - 1);
    end_test("short frame and sync while busy");

    write_reg(REG_CTRL, 32'h0001_0a21);
    read_reg(REG_STATUS, st);
    check_eq("status", st, {16'd0, fcnt, 8'h02});
    drive_ext(1'b1, 1'b1, 1'b0);
    drive_ext(1'b0, 1'b0, 1'b0);
    drive_ext(1'b1, 1'b0, 1'b0);
    pulse_sync();
    wait_cycles(20);
    read_reg(REG_STATUS, st);
    check_eq("status", st, {16'd0, fcnt, 8'h02});  // no frame in direct mode
    write_reg(REG_CTRL, 32'h0000_0a21);
    read_reg(REG_STATUS, st);
    check_eq("status", st, {16'd0, fcnt, 8'h00});
    check_eq("adxl_csn", adxl_csn, 1'b1);  // reader owns the pins again
    check_eq("adxl_sclk", adxl_sclk, 1'b0);
    end_test("direct pin access");

    $display("tests %0d, checks %0d, errors %0d", test_no - 1, checks, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== wb_regs.sv ====
// wishbone classic register block for the reader
// control word, status with frame count, and the 12-byte sample store
`timescale 1ns/10ps

module wb_regs import accel_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic [3:0]  wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack,
  input  store_wr_t   store_wr,
  input  logic        busy,
  input  logic        direct_en,
  input  logic        frame_done,
  output ctrl_reg_t   ctrl
);

  logic [7:0]  store [STORE_BYTES];
  logic [7:0]  frame_cnt;
  logic [31:0] status;
  logic [31:0] rd_word;
  logic [3:0]  samp_word;  // sample word index
  logic        req;

  assign req       = wb_cyc && wb_stb && !wb_ack;  // ack follows next clk
  assign status    = {16'd0, frame_cnt, 6'd0, direct_en, busy};
  assign samp_word = wb_adr - REG_SAMPLE0;

  always_comb
  begin
    rd_word = '0;  // unmapped reads give zero
    if (wb_adr == REG_CTRL)
      rd_word = ctrl;
    else if (wb_adr == REG_STATUS)
      rd_word = status;
    else if (wb_adr >= REG_SAMPLE0 && int'(samp_word) < STORE_BYTES / 4)
      for (int k = 0; k < 4; k++)
        rd_word[8*k +: 8] = store[4*samp_word + k];  // lowest byte in bits 7:0
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wb_ack <= 1'b0;
      ctrl   <= '{cmd: 8'h01, len: 4'(MAX_LEN), default: 0};  // read id
    end
    else
    begin
      wb_ack <= req;
      if (req && wb_we && wb_adr == REG_CTRL)
        ctrl <= wb_dat_w;
    end
  end

  always_ff @(posedge clk)
  begin
    if (req)
      wb_dat_r <= rd_word;  // valid with ack
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      frame_cnt <= '0;
      for (int i = 0; i < STORE_BYTES; i++)
        store[i] <= '0;
    end
    else
    begin
      if (frame_done)
        frame_cnt <= frame_cnt + 8'd1;
      if (store_wr.en)
        store[store_wr.addr] <= store_wr.data;
    end
  end

endmodule

// ==== xfer_fsm.sv ====
// frame sequencer for the spi reader
// owns csn and sclk, the direct access grant, the ch1 drain and busy
`timescale 1ns/10ps

module xfer_fsm import accel_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       tick,
  input  logic [7:0] half_cnt,
  input  logic       sync,
  input  ctrl_reg_t  ctrl,
  input  logic       drain_done,
  output logic       run,
  output xfer_cfg_t  cfg,
  output spi_pins_t  pins,
  output logic       drain,
  output logic       busy,
  output logic       direct_en,
  output logic       frame_done
);

  typedef enum logic [2:0] {IDLE, SELECT, SHIFT, DESELECT, DRAIN} state_t;

  state_t state;
  logic   sync_q;  // previous sync for edge detect
  logic   start;
  logic   csn_r;
  logic   sclk_r;

  // rising sync starts a frame only when idle and not granted to the host
  assign start      = (state == IDLE) && sync && !sync_q && !direct_en;
  assign drain      = (state == DESELECT);  // one clk wide
  assign frame_done = (state == DRAIN) && drain_done;
  // mosi itself comes from spi_shift, held low here
  assign pins       = '{sclk: sclk_r, mosi: 1'b0, csn: csn_r};

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= IDLE;
      sync_q    <= 1'b0;
      run       <= 1'b0;
      busy      <= 1'b0;
      direct_en <= 1'b0;
      csn_r     <= 1'b1;
      sclk_r    <= 1'b0;
      cfg       <= '0;
    end
    else
    begin
      sync_q <= sync;
      case (state)
        IDLE:
          if (start)
          begin
            cfg   <= '{cmd: ctrl.cmd, len: ctrl.len};
            run   <= 1'b1;  // timer starts counting
            busy  <= 1'b1;
            state <= SELECT;
          end
          else
            direct_en <= ctrl.direct;  // grant moves only here
        SELECT:
          if (tick)
          begin
            csn_r <= 1'b0;  // half_cnt goes to 1
            state <= SHIFT;
          end
        SHIFT:
          if (tick)
          begin
            if (half_cnt > {cfg.len, 4'h0})
            begin
              // one tick after the last falling edge
              csn_r  <= 1'b1;
              sclk_r <= 1'b0;
              run    <= 1'b0;
              state  <= DESELECT;
            end
            else
              sclk_r <= half_cnt[0];  // even count after the tick means high
          end
        DESELECT:
          state <= DRAIN;  // drain pulse goes out this clk
        DRAIN:
          if (drain_done)
          begin
            busy  <= 1'b0;  // frame count bumps on the same edge
            state <= IDLE;
          end
        default:
          state <= IDLE;
      endcase
    end
  end

endmodule
